// ==== source/execPkg.sv ====
package execPkg;

	// Datapath sizes
	localparam int DataWidth = 16;
	localparam int OpcodeWidth = 8;
	localparam int RegCount = 16;
	localparam int RegAddrWidth = 4;

	// Operation selected by the low opcode nibble
	localparam logic [3:0] OpAdd = 4'd1;
	localparam logic [3:0] OpSub = 4'd2;
	localparam logic [3:0] OpXor = 4'd3;
	localparam logic [3:0] OpOr = 4'd4;
	localparam logic [3:0] OpAnd = 4'd5;
	localparam logic [3:0] OpNot = 4'd6;
	localparam logic [3:0] OpMov = 4'd7;
	localparam logic [3:0] OpCmp = 4'd8;
	localparam logic [3:0] OpJump = 4'd9;
	localparam logic [3:0] OpLsh = 4'd11;
	localparam logic [3:0] OpRsh = 4'd12;

	// Set for a constant second argument
	localparam int ImmBit = 5;

	// Jump conditions, tested against the stored flags
	localparam logic [2:0] CondAlways = 3'd0;
	localparam logic [2:0] CondNotZero = 3'd1;
	localparam logic [2:0] CondZero = 3'd2;
	localparam logic [2:0] CondGreater = 3'd3;
	localparam logic [2:0] CondSmaller = 3'd4;
	localparam logic [2:0] CondEqual = 3'd5;
	localparam logic [2:0] CondNotEqual = 3'd6;
	localparam logic [2:0] CondGreaterEqual = 3'd7;

	// Sequencer states
	localparam logic StateIdle = 1'b0;
	localparam logic StateExec = 1'b1;

	// Upper nibble reads differently for ALU/MOV and for jumps
	typedef union packed {
		struct packed {
			logic [OpcodeWidth-1:ImmBit+1] reservedHigh;
			logic imm;
			logic [ImmBit-1:4] reservedLow;
			logic [3:0] op;
		} aluView;
		struct packed {
			logic regTarget;
			logic [2:0] cond;
			logic [3:0] op;
		} jumpView;
	} instrWord_u;

	typedef struct packed {
		logic equal;
		logic greater;
		logic zero;
	} flags_s;

	typedef enum logic [3:0] {
		AluAdd,
		AluSub,
		AluXor,
		AluOr,
		AluAnd,
		AluNot,
		AluLsh,
		AluRsh,
		AluCmp
	} aluOp_e;

endpackage

// ==== source/regFileIf.sv ====
interface regFileIf;

	// Two read ports, both addressed by the sequencer
	logic [execPkg::RegAddrWidth-1:0] readAddrA;
	logic [execPkg::RegAddrWidth-1:0] readAddrB;
	logic [execPkg::DataWidth-1:0] readDataA;
	logic [execPkg::DataWidth-1:0] readDataB;

	// Single write port
	logic writeEn;
	logic [execPkg::RegAddrWidth-1:0] writeAddr;
	logic [execPkg::DataWidth-1:0] writeData;

	modport seq (
		output readAddrA,
		output readAddrB,
		output writeEn,
		output writeAddr,
		output writeData,
		input readDataA,
		input readDataB
	);

	modport rf (
		input readAddrA,
		input readAddrB,
		input writeEn,
		input writeAddr,
		input writeData,
		output readDataA,
		output readDataB
	);

endinterface

// ==== source/registerFile.sv ====
module registerFile (
	input logic clk,
	input logic rst,
	regFileIf.rf rfPort
);

	logic [execPkg::DataWidth-1:0] regs [execPkg::RegCount];

	// Whole file comes up as zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < execPkg::RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (rfPort.writeEn) begin
			regs[rfPort.writeAddr] <= rfPort.writeData;
		end
	end

	// Reads see the stored value, not the one being written
	assign rfPort.readDataA = regs[rfPort.readAddrA];
	assign rfPort.readDataB = regs[rfPort.readAddrB];

	// Sequencer must present clean write data on every write
	writeKnown: assert property (
		@(posedge clk) disable iff (rst)
		rfPort.writeEn |-> !$isunknown({rfPort.writeAddr, rfPort.writeData})
	);

endmodule

// ==== source/alu.sv ====
module alu (
	input logic [execPkg::DataWidth-1:0] opA,
	input logic [execPkg::DataWidth-1:0] opB,
	input execPkg::aluOp_e op,
	output logic [execPkg::DataWidth-1:0] result,
	output execPkg::flags_s nextFlags
);

	always_comb begin
		case (op)
			execPkg::AluAdd: begin
				// Carry out is dropped
				result = opA + opB;
			end
			execPkg::AluSub: begin
				result = opA - opB;
			end
			execPkg::AluXor: begin
				result = opA ^ opB;
			end
			execPkg::AluOr: begin
				result = opA | opB;
			end
			execPkg::AluAnd: begin
				result = opA & opB;
			end
			execPkg::AluNot: begin
				result = ~opA;
			end
			execPkg::AluLsh: begin
				result = {opA[execPkg::DataWidth-2:0], 1'b0};
			end
			execPkg::AluRsh: begin
				// Logical shift, zero comes in at the top
				result = {1'b0, opA[execPkg::DataWidth-1:1]};
			end
			execPkg::AluCmp: begin
				result = opA;
			end
			default: begin
				result = opA;
			end
		endcase
	end

	// Compare is unsigned
	always_comb begin
		nextFlags.equal = (opA == opB);
		nextFlags.greater = (opA > opB);
		nextFlags.zero = (result == '0);
	end

	// Subtract and xor give zero exactly when the operands match
	zeroMatchesResult: assert final (
		$isunknown({opA, opB}) || !(op inside {execPkg::AluSub, execPkg::AluXor})
			|| (nextFlags.zero == nextFlags.equal)
	);

endmodule

// ==== source/instrSequencer.sv ====
module instrSequencer (
	input logic clk,
	input logic rst,
	input logic instrValid,
	output logic instrReady,
	input logic [execPkg::OpcodeWidth-1:0] opcode,
	input logic [execPkg::DataWidth-1:0] arg1,
	input logic [execPkg::DataWidth-1:0] arg2,
	regFileIf.seq rfPort,
	output logic [execPkg::DataWidth-1:0] aluOpA,
	output logic [execPkg::DataWidth-1:0] aluOpB,
	output execPkg::aluOp_e aluOp,
	input logic [execPkg::DataWidth-1:0] aluResult,
	input execPkg::flags_s aluFlags,
	output logic retire,
	output logic retireWrite,
	output logic [execPkg::DataWidth-1:0] retireData,
	output execPkg::flags_s flags,
	output logic jumpTaken,
	output logic [execPkg::DataWidth-1:0] jumpTarget
);

	logic state;
	execPkg::instrWord_u instrReg;
	logic [execPkg::DataWidth-1:0] arg1Reg;
	logic [execPkg::DataWidth-1:0] arg2Reg;
	logic useAlu;
	logic isCmp;
	logic isMov;
	logic isJump;
	logic regWrite;
	logic condMet;
	logic [execPkg::DataWidth-1:0] writeValue;

	assign instrReady = (state == execPkg::StateIdle);

	// Idle waits for an instruction, Exec lasts exactly one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= execPkg::StateIdle;
		end else if (state == execPkg::StateIdle) begin
			if (instrValid) begin
				state <= execPkg::StateExec;
			end
		end else begin
			state <= execPkg::StateIdle;
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid && instrReady) begin
			instrReg <= opcode;
			arg1Reg <= arg1;
			arg2Reg <= arg2;
		end
	end

	// Operation class from the shared op nibble
	always_comb begin
		useAlu = 1'b0;
		isCmp = 1'b0;
		isMov = 1'b0;
		isJump = 1'b0;
		aluOp = execPkg::AluAdd;
		case (instrReg.aluView.op)
			execPkg::OpAdd: begin
				useAlu = 1'b1;
				aluOp = execPkg::AluAdd;
			end
			execPkg::OpSub: begin
				useAlu = 1'b1;
				aluOp = execPkg::AluSub;
			end
			execPkg::OpXor: begin
				useAlu = 1'b1;
				aluOp = execPkg::AluXor;
			end
			execPkg::OpOr: begin
				useAlu = 1'b1;
				aluOp = execPkg::AluOr;
			end
			execPkg::OpAnd: begin
				useAlu = 1'b1;
				aluOp = execPkg::AluAnd;
			end
			execPkg::OpNot: begin
				useAlu = 1'b1;
				aluOp = execPkg::AluNot;
			end
			execPkg::OpLsh: begin
				useAlu = 1'b1;
				aluOp = execPkg::AluLsh;
			end
			execPkg::OpRsh: begin
				useAlu = 1'b1;
				aluOp = execPkg::AluRsh;
			end
			execPkg::OpCmp: begin
				isCmp = 1'b1;
				aluOp = execPkg::AluCmp;
			end
			execPkg::OpMov: isMov = 1'b1;
			execPkg::OpJump: isJump = 1'b1;
			// Unknown opcodes fall through and retire with no effect
			default: ;
		endcase
	end

	assign rfPort.readAddrA = arg1Reg[execPkg::RegAddrWidth-1:0];
	assign rfPort.readAddrB = arg2Reg[execPkg::RegAddrWidth-1:0];

	// Operand B doubles as the MOV source
	assign aluOpA = rfPort.readDataA;
	assign aluOpB = instrReg.aluView.imm ? arg2Reg : rfPort.readDataB;

	assign regWrite = useAlu || isMov;
	assign writeValue = isMov ? aluOpB : aluResult;

	assign rfPort.writeEn = (state == execPkg::StateExec) && regWrite;
	assign rfPort.writeAddr = arg1Reg[execPkg::RegAddrWidth-1:0];
	assign rfPort.writeData = writeValue;

	always_comb begin
		case (instrReg.jumpView.cond)
			execPkg::CondAlways: condMet = 1'b1;
			execPkg::CondNotZero: condMet = !flags.zero;
			execPkg::CondZero: condMet = flags.zero;
			execPkg::CondGreater: condMet = flags.greater;
			execPkg::CondSmaller: condMet = !flags.equal && !flags.greater;
			execPkg::CondEqual: condMet = flags.equal;
			execPkg::CondNotEqual: condMet = !flags.equal;
			execPkg::CondGreaterEqual: condMet = flags.equal || flags.greater;
			default: condMet = 1'b0;
		endcase
	end

	// Closing edge of Exec retires the instruction
	always_ff @(posedge clk) begin
		if (rst) begin
			retire <= 1'b0;
			retireWrite <= 1'b0;
			jumpTaken <= 1'b0;
			flags <= '0;
		end else begin
			retire <= (state == execPkg::StateExec);
			if (state == execPkg::StateExec) begin
				retireWrite <= regWrite;
				jumpTaken <= isJump && condMet;
				if (useAlu || isCmp) begin
					flags <= aluFlags;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == execPkg::StateExec) begin
			retireData <= (regWrite || isCmp) ? writeValue : '0;
			if (isJump && condMet) begin
				jumpTarget <= instrReg.jumpView.regTarget ? rfPort.readDataA : arg1Reg;
			end
		end
	end

	// Busy while executing, then retired with ready back up
	acceptThenBusy: assert property (
		@(posedge clk) disable iff (rst)
		instrValid && instrReady |=> !instrReady ##1 (retire && instrReady)
	);

	noBackToBackRetire: assert property (
		@(posedge clk) disable iff (rst)
		retire |=> !retire
	);

endmodule

// ==== source/instrExecutor.sv ====
module instrExecutor (
	input logic clk,
	input logic rst,
	input logic instrValid,
	output logic instrReady,
	input logic [execPkg::OpcodeWidth-1:0] opcode,
	input logic [execPkg::DataWidth-1:0] arg1,
	input logic [execPkg::DataWidth-1:0] arg2,
	output logic retire,
	output logic retireWrite,
	output logic [execPkg::DataWidth-1:0] retireData,
	output execPkg::flags_s flags,
	output logic jumpTaken,
	output logic [execPkg::DataWidth-1:0] jumpTarget
);

	logic [execPkg::DataWidth-1:0] aluOpA;
	logic [execPkg::DataWidth-1:0] aluOpB;
	execPkg::aluOp_e aluOp;
	logic [execPkg::DataWidth-1:0] aluResult;
	execPkg::flags_s aluFlags;

	regFileIf rfBus ();

	instrSequencer seqUnit (
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.opcode(opcode),
		.arg1(arg1),
		.arg2(arg2),
		.rfPort(rfBus.seq),
		.aluOpA(aluOpA),
		.aluOpB(aluOpB),
		.aluOp(aluOp),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.retire(retire),
		.retireWrite(retireWrite),
		.retireData(retireData),
		.flags(flags),
		.jumpTaken(jumpTaken),
		.jumpTarget(jumpTarget)
	);

	alu aluUnit (
		.opA(aluOpA),
		.opB(aluOpB),
		.op(aluOp),
		.result(aluResult),
		.nextFlags(aluFlags)
	);

	registerFile regFile (
		.clk(clk),
		.rst(rst),
		.rfPort(rfBus.rf)
	);

endmodule

// ==== verif/execChecker.sv ====
module execChecker (
	input logic clk,
	input logic rst,
	input logic instrReady,
	input logic retire,
	input logic retireWrite,
	input logic [execPkg::DataWidth-1:0] retireData,
	input execPkg::flags_s flags,
	input logic jumpTaken,
	input logic [execPkg::DataWidth-1:0] jumpTarget,
	output int passCount,
	output int failCount,
	output int pendingCount
);

	localparam int RetireLimit = 16;

	typedef struct packed {
		logic derived;
		logic [execPkg::OpcodeWidth-1:0] op;
		logic [execPkg::DataWidth-1:0] arg2;
		logic write;
		logic [execPkg::DataWidth-1:0] data;
		logic [2:0] flagBits;
		logic jump;
		logic [execPkg::DataWidth-1:0] target;
	} caseEntry_s;

	caseEntry_s pending[$];
	caseEntry_s current;
	logic [2:0] lastFlags;
	logic prevRetire;
	logic resetChecked;
	logic caseBad;
	int testIndex;
	int idleCycles;

	initial begin
		passCount = 0;
		failCount = 0;
		pendingCount = 0;
		lastFlags = '0;
		resetChecked = 1'b0;
		testIndex = 0;
	end

	// Driver calls this once the DUT has accepted an instruction
	task automatic queueCase(
		input logic derived,
		input logic [execPkg::OpcodeWidth-1:0] op,
		input logic [execPkg::DataWidth-1:0] arg2,
		input logic write,
		input logic [execPkg::DataWidth-1:0] data,
		input logic [2:0] flagBits,
		input logic jump,
		input logic [execPkg::DataWidth-1:0] target
	);
		caseEntry_s entry;
		entry = {derived, op, arg2, write, data, flagBits, jump, target};
		pending.push_back(entry);
		pendingCount = pending.size();
	endtask

	task automatic compareField(
		input string name,
		input logic [execPkg::DataWidth-1:0] expVal,
		input logic [execPkg::DataWidth-1:0] gotVal
	);
		if (gotVal !== expVal) begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expVal, gotVal);
			caseBad = 1'b1;
		end
	endtask

	task automatic checkRetired(input caseEntry_s entry);
		caseEntry_s expected;
		expected = entry;
		// MOV immediate writes its constant and leaves the flags alone
		if (entry.derived) begin
			expected.write = 1'b1;
			expected.data = entry.arg2;
			expected.flagBits = lastFlags;
			expected.jump = 1'b0;
		end
		caseBad = 1'b0;
		compareField("retireWrite", expected.write, retireWrite);
		compareField("retireData", expected.data, retireData);
		compareField("flags", expected.flagBits, flags);
		compareField("jumpTaken", expected.jump, jumpTaken);
		// Target only moves on a taken jump
		if (expected.jump) begin
			compareField("jumpTarget", expected.target, jumpTarget);
		end
		lastFlags = expected.flagBits;
		testIndex++;
		if (caseBad) begin
			failCount++;
			$display("Test %0d, opcode %h: failed", testIndex, entry.op);
		end else begin
			passCount++;
			$display("Test %0d, opcode %h: passed", testIndex, entry.op);
		end
	endtask

	always @(negedge clk) begin
		if (rst) begin
			prevRetire = 1'b0;
			idleCycles = 0;
		end else begin
			if (!resetChecked) begin
				resetChecked = 1'b1;
				testIndex++;
				if (instrReady === 1'b1 && retire === 1'b0) begin
					passCount++;
					$display("Test %0d, state after reset: passed", testIndex);
				end else begin
					failCount++;
					$display("Test %0d, state after reset: failed, instrReady %b and retire %b",
						testIndex, instrReady, retire);
				end
			end
			if (retire === 1'b1 && prevRetire) begin
				failCount++;
				$display("retire stayed high for two cycles in a row at %0t", $time);
			end
			if (retire === 1'b1) begin
				idleCycles = 0;
				if (pending.size() == 0) begin
					failCount++;
					$display("retire pulsed at %0t with no instruction outstanding", $time);
				end else begin
					current = pending.pop_front();
					checkRetired(current);
				end
			end else if (pending.size() != 0) begin
				idleCycles++;
				if (idleCycles > RetireLimit) begin
					current = pending.pop_front();
					testIndex++;
					failCount++;
					$display("Test %0d, opcode %h never retired", testIndex, current.op);
					idleCycles = 0;
				end
			end
			prevRetire = (retire === 1'b1);
			pendingCount = pending.size();
		end
	end

endmodule

// ==== verif/tbInstrExecutor.sv ====
module tbInstrExecutor;

	localparam int ReadyLimit = 16;
	localparam int DrainLimit = 64;

	logic clk;
	logic rst;
	logic instrValid;
	logic instrReady;
	logic [execPkg::OpcodeWidth-1:0] opcode;
	logic [execPkg::DataWidth-1:0] arg1;
	logic [execPkg::DataWidth-1:0] arg2;
	logic retire;
	logic retireWrite;
	logic [execPkg::DataWidth-1:0] retireData;
	execPkg::flags_s flags;
	logic jumpTaken;
	logic [execPkg::DataWidth-1:0] jumpTarget;
	int passCount;
	int failCount;
	int pendingCount;
	logic aborted;
	logic [31:0] rngState;

	instrExecutor i_dut (.*);

	execChecker i_checker (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Starts and ends on a falling edge, valid stays high for the next one
	task automatic issue(
		input logic derived,
		input logic [execPkg::OpcodeWidth-1:0] op,
		input logic [execPkg::DataWidth-1:0] a1,
		input logic [execPkg::DataWidth-1:0] a2,
		input logic expWrite,
		input logic [execPkg::DataWidth-1:0] expData,
		input logic [2:0] expFlags,
		input logic expJump,
		input logic [execPkg::DataWidth-1:0] expTarget
	);
		int waited;
		opcode = op;
		arg1 = a1;
		arg2 = a2;
		instrValid = 1'b1;
		waited = 0;
		while (instrReady !== 1'b1 && waited < ReadyLimit) begin
			@(negedge clk);
			waited++;
		end
		if (instrReady !== 1'b1) begin
			$display("instrReady stayed low for %0d cycles, opcode %h was not taken", waited, op);
			aborted = 1'b1;
		end else begin
			@(posedge clk);
			i_checker.queueCase(derived, op, a2, expWrite, expData, expFlags, expJump, expTarget);
			@(negedge clk);
		end
	endtask

	initial begin
		int fd;
		int got;
		int fields;
		int waited;
		string line;
		logic [3:0] kind;
		logic [execPkg::OpcodeWidth-1:0] op;
		logic [execPkg::DataWidth-1:0] a1;
		logic [execPkg::DataWidth-1:0] a2;
		logic expWrite;
		logic [execPkg::DataWidth-1:0] expData;
		logic [2:0] expFlags;
		logic expJump;
		logic [execPkg::DataWidth-1:0] expTarget;
		rst = 1'b1;
		instrValid = 1'b0;
		opcode = '0;
		arg1 = '0;
		arg2 = '0;
		aborted = 1'b0;
		rngState = 32'h5b53;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// One quiet cycle so the checker sees the idle state after reset
		@(negedge clk);
		fd = $fopen("verif/execCases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file verif/execCases.txt");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			got = $fgets(line, fd);
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", kind, op, a1, a2,
				expWrite, expData, expFlags, expJump, expTarget);
			// Comment lines do not parse
			if (got != 0 && fields == 9) begin
				if (kind == 4'd1) begin
					rngState = xorshift(rngState);
					a2 = rngState[execPkg::DataWidth-1:0];
				end
				issue(kind == 4'd1, op, a1, a2, expWrite, expData, expFlags, expJump, expTarget);
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		instrValid = 1'b0;
		waited = 0;
		while (pendingCount != 0 && waited < DrainLimit) begin
			@(negedge clk);
			waited++;
		end
		if (pendingCount != 0) begin
			$display("Instructions were still outstanding when the run ended");
			aborted = 1'b1;
		end
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (aborted || failCount != 0) begin
			$display("Finished with errors");
		end else begin
			$display("Finished with no errors");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
source/execPkg.sv
source/regFileIf.sv
source/registerFile.sv
source/alu.sv
source/instrSequencer.sv
source/instrExecutor.sv
verif/execChecker.sv
verif/tbInstrExecutor.sv

// ==== Bender.yml ====
package:
  name: instr_executor

sources:
  - source/execPkg.sv
  - source/regFileIf.sv
  - source/registerFile.sv
  - source/alu.sv
  - source/instrSequencer.sv
  - source/instrExecutor.sv
  - target: test
    files:
      - verif/execChecker.sv
      - verif/tbInstrExecutor.sv

// ==== verif/execCases.txt ====
// kind (1 = MOV immediate with a random arg2, expected values derived) opcode arg1 arg2
// then expected retireWrite retireData flags (equal greater zero) jumpTaken jumpTarget, in hex
0 27 0001 1234 1 1234 0 0 0000
1 27 000f 0000 0 0000 0 0 0000
0 27 0002 f0f0 1 f0f0 0 0 0000
0 07 0003 0001 1 1234 0 0 0000
0 21 0002 1000 1 00f0 2 0 0000
0 27 0004 0005 1 0005 2 0 0000
0 22 0004 0006 1 ffff 0 0 0000
0 02 0003 0001 1 0000 5 0 0000
0 07 0005 0003 1 0000 5 0 0000
0 03 0001 0002 1 12c4 2 0 0000
0 23 0006 0000 1 0000 5 0 0000
0 24 0002 0f00 1 0ff0 0 0 0000
0 05 0002 0001 1 02c0 0 0 0000
0 25 0007 ffff 1 0000 1 0 0000
0 06 0007 0000 1 ffff 4 0 0000
0 26 0004 ffff 1 0000 5 0 0000
0 0b 0007 0000 1 fffe 2 0 0000
0 0c 0007 0000 1 7fff 2 0 0000
0 0c 0007 0000 1 3fff 2 0 0000
0 08 0001 0001 0 12c4 4 0 0000
0 09 0100 0000 0 0000 4 1 0100
0 59 0200 0000 0 0000 4 1 0200
0 69 0300 0000 0 0000 4 0 0000
0 f9 0002 0000 0 0000 4 1 02c0
0 39 0400 0000 0 0000 4 0 0000
0 28 0001 0100 0 12c4 2 0 0000
0 39 0400 0000 0 0000 2 1 0400
0 99 0001 0000 0 0000 2 1 12c4
0 29 0500 0000 0 0000 2 0 0000
0 08 0005 0001 0 0000 1 0 0000
0 49 0500 0000 0 0000 1 1 0500
0 a9 0007 0000 0 0000 1 1 3fff
0 0f 0001 0002 0 0000 1 0 0000
1 27 000f 0000 0 0000 0 0 0000
